// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_spi_cmd_hub
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
SIM       := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: build
	./$(SIM) | tee $(LOG)
	grep -qx "test passed" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: logic/spi_cmd_dispatch.sv
`default_nettype none

module spi_cmd_dispatch
  import spi_hub_pkg::*;
(
  input  wire                 clk,
  input  wire                 rst_n,
  input  wire                 cmd_valid,
  output logic                cmd_ready,
  input  wire chan_id_t       cmd_chan,
  input  wire cmd_word_t      cmd_word,
  output logic [num_chan-1:0] eng_valid,
  input  wire  [num_chan-1:0] eng_ready,
  output cmd_word_t           eng_word
);

  // Word goes to every engine, only one sees valid
  assign eng_word  = cmd_word;
  assign cmd_ready = eng_ready[cmd_chan];

  always_comb
  begin
    eng_valid           = '0;
    eng_valid[cmd_chan] = cmd_valid;
  end

  // Host must keep cmd_valid low during reset
  a_eng_valid_reset: assert property (
    @(posedge clk) !rst_n |-> eng_valid == '0
  );

endmodule

`default_nettype wire

// File: logic/spi_cmd_engine.sv
`default_nettype none

module spi_cmd_engine
  import spi_hub_pkg::*;
#(
  parameter int sclk_half = 5,
  parameter int read_gap  = 100
) (
  input  wire       clk,
  input  wire       rst_n,
  input  wire       cmd_valid,
  output logic      cmd_ready,
  input  wire cmd_word_t cmd_word,
  output logic      res_valid,
  input  wire       res_ready,
  output reg_data_t res_data,
  output logic      sclk,
  output logic      cs_n,
  output logic      mosi,
  input  wire       miso
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_WR_SHIFT,
    ST_RD_HDR,
    ST_RD_GAP,
    ST_RD_SHIFT,
    ST_RES_HOLD,
    ST_FINISH
  } eng_state_e;

  localparam int div_w = $clog2(sclk_half + 1);
  localparam int gap_w = $clog2(read_gap + 1);

  eng_state_e       state;
  logic [div_w-1:0] div_cnt;
  logic [gap_w-1:0] gap_cnt;
  logic [3:0]       bit_cnt;
  logic             rd_op;
  cmd_word_t        shreg;   // Out bits leave at the top, in bits enter at the bottom
  logic             accept;
  logic             shifting;
  logic             half_done;
  logic             sclk_rise;
  logic             sclk_fall;
  logic             bit_last;

  assign accept    = cmd_valid && cmd_ready;
  assign cmd_ready = (state == ST_IDLE);
  assign res_valid = (state == ST_RES_HOLD);
  assign res_data  = shreg[data_bits-1:0];

  assign shifting  = state inside {ST_WR_SHIFT, ST_RD_HDR, ST_RD_SHIFT};
  assign half_done = shifting && (div_cnt == div_w'(sclk_half - 1));
  assign sclk_rise = half_done && !sclk;
  assign sclk_fall = half_done && sclk; // End of one bit
  assign mosi      = shreg[cmd_write_bit] && (state inside {ST_WR_SHIFT, ST_RD_HDR});

  always_comb
  begin
    case (state)
      ST_WR_SHIFT: bit_last = (bit_cnt == 4'(cmd_bits - 1));
      ST_RD_HDR:   bit_last = (bit_cnt == 4'(hdr_bits - 1));
      default:     bit_last = (bit_cnt == 4'(data_bits - 1));
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state   <= ST_IDLE;
      div_cnt <= '0;
      gap_cnt <= '0;
      bit_cnt <= '0;
      rd_op   <= 1'b0;
      sclk    <= 1'b0;
      cs_n    <= 1'b1;
    end
    else
    begin
      div_cnt <= (half_done || !shifting) ? '0 : div_cnt + 1'b1;
      if (half_done)
        sclk <= !sclk;
      if (sclk_fall)
        bit_cnt <= bit_cnt + 1'b1;

      case (state)
        ST_IDLE:
          if (accept)
          begin
            rd_op   <= !cmd_word[cmd_write_bit];
            cs_n    <= 1'b0;
            bit_cnt <= '0;
            state   <= cmd_word[cmd_write_bit] ? ST_WR_SHIFT : ST_RD_HDR;
          end
        ST_WR_SHIFT, ST_RD_SHIFT:
          if (sclk_fall && bit_last)
            state <= ST_FINISH;
        ST_RD_HDR:
          if (sclk_fall && bit_last)
          begin
            cs_n    <= 1'b1; // Gap between header and data
            gap_cnt <= '0;
            state   <= ST_RD_GAP;
          end
        ST_RD_GAP:
          if (gap_cnt == gap_w'(read_gap - 1))
          begin
            cs_n    <= 1'b0;
            bit_cnt <= '0;
            state   <= ST_RD_SHIFT;
          end
          else
          begin
            gap_cnt <= gap_cnt + 1'b1;
          end
        ST_FINISH:
          // One cycle cs_n low after the last edge, then one cycle high
          if (!cs_n)
            cs_n <= 1'b1;
          else if (rd_op)
            state <= ST_RES_HOLD;
          else
            state <= ST_IDLE;
        ST_RES_HOLD:
          if (res_ready)
            state <= ST_IDLE;
        default:
          state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
      shreg <= cmd_word;
    else if (sclk_fall && state != ST_RD_SHIFT)
      shreg <= shreg << 1;
    else if (sclk_rise && state == ST_RD_SHIFT)
      shreg <= {shreg[cmd_bits-2:0], miso}; // MSB first
  end

  a_sclk_low_when_idle: assert property (
    @(posedge clk) disable iff (!rst_n) cs_n |-> !sclk
  );

  a_res_stable: assert property (
    @(posedge clk) disable iff (!rst_n)
      res_valid && !res_ready |=> res_valid && $stable(res_data)
  );

endmodule

`default_nettype wire

// File: logic/spi_cmd_hub.sv
`default_nettype none

module spi_cmd_hub
  import spi_hub_pkg::*;
#(
  parameter int sclk_half = 5,
  parameter int read_gap  = 100
) (
  input  wire                clk,
  input  wire                rst_n,
  input  wire                cmd_valid,
  output wire                cmd_ready,
  input  wire chan_id_t      cmd_chan,
  input  wire cmd_word_t     cmd_word,
  output wire                rd_valid,
  input  wire                rd_ready,
  output chan_id_t           rd_chan,
  output reg_data_t          rd_data,
  output wire [num_chan-1:0] sclk,
  output wire [num_chan-1:0] cs_n,
  output wire [num_chan-1:0] mosi,
  input  wire [num_chan-1:0] miso
);

  wire [num_chan-1:0] eng_valid;
  wire [num_chan-1:0] eng_ready;
  wire [num_chan-1:0] res_valid;
  wire [num_chan-1:0] res_ready;
  wire cmd_word_t     eng_word;
  wire reg_data_t     res_data [num_chan];

  spi_cmd_dispatch i_dispatch (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_valid (cmd_valid),
    .cmd_ready (cmd_ready),
    .cmd_chan  (cmd_chan),
    .cmd_word  (cmd_word),
    .eng_valid (eng_valid),
    .eng_ready (eng_ready),
    .eng_word  (eng_word)
  );

  for (genvar g = 0; g < num_chan; g++)
  begin : g_eng
    spi_cmd_engine #(
      .sclk_half (sclk_half),
      .read_gap  (read_gap)
    ) i_engine (
      .clk       (clk),
      .rst_n     (rst_n),
      .cmd_valid (eng_valid[g]),
      .cmd_ready (eng_ready[g]),
      .cmd_word  (eng_word),
      .res_valid (res_valid[g]),
      .res_ready (res_ready[g]),
      .res_data  (res_data[g]),
      .sclk      (sclk[g]),
      .cs_n      (cs_n[g]),
      .mosi      (mosi[g]),
      .miso      (miso[g])
    );
  end

  spi_read_collect i_collect (
    .clk       (clk),
    .rst_n     (rst_n),
    .res_valid (res_valid),
    .res_ready (res_ready),
    .res_data  (res_data),
    .rd_valid  (rd_valid),
    .rd_ready  (rd_ready),
    .rd_chan   (rd_chan),
    .rd_data   (rd_data)
  );

endmodule

`default_nettype wire

// File: logic/spi_hub_pkg.sv
`default_nettype none

package spi_hub_pkg;

  localparam int num_chan = 4;

  localparam int cmd_bits  = 12;
  localparam int data_bits = 8;
  localparam int hdr_bits  = 4; // Write flag plus address

  // Command field positions
  localparam int cmd_write_bit = 11;
  localparam int cmd_addr_msb  = 10;
  localparam int cmd_addr_lsb  = 8;

  typedef logic [cmd_bits-1:0]         cmd_word_t;
  typedef logic [2:0]                  reg_addr_t;
  typedef logic [data_bits-1:0]        reg_data_t;
  typedef logic [$clog2(num_chan)-1:0] chan_id_t;

  // Accepted command counter, wraps
  typedef logic [15:0] cmd_count_t;

endpackage

`default_nettype wire

// File: logic/spi_read_collect.sv
`default_nettype none

module spi_read_collect
  import spi_hub_pkg::*;
(
  input  wire                 clk,
  input  wire                 rst_n,
  input  wire  [num_chan-1:0] res_valid,
  output logic [num_chan-1:0] res_ready,
  input  wire reg_data_t      res_data [num_chan],
  output logic                rd_valid,
  input  wire                 rd_ready,
  output chan_id_t            rd_chan,
  output reg_data_t           rd_data
);

  chan_id_t rr_ptr;     // Highest priority channel
  chan_id_t grant_chan;
  logic     grant_any;
  logic     load;

  // Output register empty or draining this cycle
  assign load = !rd_valid || rd_ready;

  always_comb
  begin
    grant_any  = 1'b0;
    grant_chan = rr_ptr;
    for (int k = 0; k < num_chan; k++)
    begin
      if (!grant_any && res_valid[chan_id_t'(rr_ptr + chan_id_t'(k))])
      begin
        grant_any  = 1'b1;
        grant_chan = chan_id_t'(rr_ptr + chan_id_t'(k));
      end
    end
  end

  always_comb
  begin
    res_ready = '0;
    if (load && grant_any)
      res_ready[grant_chan] = 1'b1;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rd_valid <= 1'b0;
      rr_ptr   <= '0;
    end
    else if (load)
    begin
      rd_valid <= grant_any;
      if (grant_any)
        rr_ptr <= grant_chan + 1'b1; // Winner drops to lowest priority
    end
  end

  always_ff @(posedge clk)
  begin
    if (load && grant_any)
    begin
      rd_chan <= grant_chan;
      rd_data <= res_data[grant_chan];
    end
  end

  a_rd_stable: assert property (
    @(posedge clk) disable iff (!rst_n)
      rd_valid && !rd_ready |=> rd_valid && $stable(rd_data) && $stable(rd_chan)
  );

endmodule

`default_nettype wire

// File: sources.f
logic/spi_hub_pkg.sv
logic/spi_cmd_dispatch.sv
logic/spi_cmd_engine.sv
logic/spi_read_collect.sv
logic/spi_cmd_hub.sv
verif/spi_slave_model.sv
verif/tb_spi_cmd_hub.sv

// File: verif/spi_slave_model.sv
`default_nettype none

module spi_slave_model
  import spi_hub_pkg::*;
(
  input  wire  clk,
  input  wire  rst_n,
  input  wire  sclk,
  input  wire  cs_n,
  input  wire  mosi,
  output logic miso,
  output logic frame_err  // Sticky
);

  reg_data_t   regs [8];
  logic        sclk_q;
  logic        cs_q;
  logic [4:0]  edge_cnt;
  logic [11:0] rx;
  logic        hdr_seen;   // Read header waiting for its data frame
  reg_addr_t   rd_addr;
  reg_data_t   tx;

  // Pins sampled on the system clock, edges found against the last sample
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < 8; i++)
        regs[i] <= '0;
      sclk_q    <= 1'b0;
      cs_q      <= 1'b1;
      edge_cnt  <= '0;
      rx        <= '0;
      hdr_seen  <= 1'b0;
      rd_addr   <= '0;
      tx        <= '0;
      miso      <= 1'b0;
      frame_err <= 1'b0;
    end
    else
    begin
      sclk_q <= sclk;
      cs_q   <= cs_n;
      if (!cs_n && cs_q)
      begin
        edge_cnt <= '0;
        rx       <= '0;
        tx       <= regs[rd_addr];
        miso     <= hdr_seen && regs[rd_addr][7]; // MSB ready before first rise
      end
      else if (!cs_n && sclk && !sclk_q)
      begin
        rx       <= {rx[10:0], mosi};
        edge_cnt <= edge_cnt + 1'b1;
      end
      else if (!cs_n && !sclk && sclk_q)
      begin
        miso <= hdr_seen && tx[6];
        tx   <= tx << 1;
      end
      else if (cs_n && !cs_q)
      begin
        miso <= 1'b0;
        case (edge_cnt)
          5'd12:
            if (!rx[11] || hdr_seen)
              frame_err <= 1'b1;
            else
              regs[rx[10:8]] <= rx[7:0];
          5'd4:
            if (rx[3] || hdr_seen)
              frame_err <= 1'b1;
            else
            begin
              hdr_seen <= 1'b1;
              rd_addr  <= rx[2:0];
            end
          5'd8:
          begin
            if (!hdr_seen)
              frame_err <= 1'b1; // Data without header
            hdr_seen <= 1'b0;
          end
          default: frame_err <= 1'b1;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

// File: verif/tb_spi_cmd_hub.sv
`default_nettype none

module tb_spi_cmd_hub
  import spi_hub_pkg::*;
();

  localparam int sclk_half    = 5;
  localparam int read_gap     = 20;
  localparam int num_cmds     = 200;
  localparam int cmd_timeout  = 2000;
  localparam int read_timeout = 4000;

  logic                clk = 1'b0;
  logic                rst_n;
  logic                cmd_valid;
  wire                 cmd_ready;
  chan_id_t            cmd_chan;
  cmd_word_t           cmd_word;
  wire                 rd_valid;
  logic                rd_ready = 1'b0;
  chan_id_t            rd_chan;
  reg_data_t           rd_data;
  wire  [num_chan-1:0] sclk;
  wire  [num_chan-1:0] cs_n;
  wire  [num_chan-1:0] mosi;
  wire  [num_chan-1:0] miso;
  wire  [num_chan-1:0] frame_err;

  // Reference model
  reg_data_t   model_regs [num_chan][8];
  reg_data_t   exp_q [num_chan][$];
  logic [31:0] cmd_rng;
  logic [31:0] stall_rng;
  logic        stall_en;
  logic        held;
  reg_data_t   held_data;
  chan_id_t    held_chan;
  chan_id_t    last_chan;
  reg_data_t   last_data;
  reg_data_t   last_by_chan [num_chan];
  logic        timed_out;
  int          reads_done;
  int          err_count;
  int          test_err_start;
  int          test_count;
  int          failed_tests;
  string       cur_test;

  always #4 clk = ~clk;

  spi_cmd_hub #(
    .sclk_half (sclk_half),
    .read_gap  (read_gap)
  ) i_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_valid (cmd_valid),
    .cmd_ready (cmd_ready),
    .cmd_chan  (cmd_chan),
    .cmd_word  (cmd_word),
    .rd_valid  (rd_valid),
    .rd_ready  (rd_ready),
    .rd_chan   (rd_chan),
    .rd_data   (rd_data),
    .sclk      (sclk),
    .cs_n      (cs_n),
    .mosi      (mosi),
    .miso      (miso)
  );

  for (genvar c = 0; c < num_chan; c++)
  begin : g_slave
    spi_slave_model i_slave (
      .clk       (clk),
      .rst_n     (rst_n),
      .sclk      (sclk[c]),
      .cs_n      (cs_n[c]),
      .mosi      (mosi[c]),
      .miso      (miso[c]),
      .frame_err (frame_err[c])
    );
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic compare_data(input string name, input reg_data_t exp, input reg_data_t act);
    if (exp !== act)
    begin
      $display("ERR %s: expected %h, actual %h", name, exp, act);
      err_count++;
    end
  endtask

  task automatic compare_chan(input string name, input chan_id_t exp, input chan_id_t act);
    if (exp !== act)
    begin
      $display("ERR %s: expected channel %0d, actual channel %0d", name, exp, act);
      err_count++;
    end
  endtask

  // A stuck wait counts once, later waits return at once
  task automatic flag_timeout(input string what);
    if (!timed_out)
    begin
      $display("%s: timeout, %s", cur_test, what);
      err_count++;
    end
    timed_out = 1'b1;
  endtask

  // Model update at the moment the hub takes the command
  task automatic apply_to_model(input chan_id_t ch, input cmd_word_t word);
    reg_addr_t addr;
    addr = word[cmd_addr_msb:cmd_addr_lsb];
    if (word[cmd_write_bit])
      model_regs[ch][addr] = word[data_bits-1:0];
    else
      exp_q[ch].push_back(model_regs[ch][addr]);
  endtask

  task automatic send_cmd(input chan_id_t ch, input cmd_word_t word);
    int   waited;
    logic done;
    waited = 0;
    done   = 1'b0;
    @(negedge clk);
    cmd_valid = 1'b1;
    cmd_chan  = ch;
    cmd_word  = word;
    while (!done && !timed_out && waited < cmd_timeout)
    begin
      #1;
      if (cmd_ready)
      begin
        apply_to_model(ch, word);
        done = 1'b1;
      end
      @(negedge clk); // Transfer at the posedge in between
      waited++;
    end
    cmd_valid = 1'b0;
    if (!done)
      flag_timeout("command never accepted");
  endtask

  task automatic wait_reads(input int target);
    int waited;
    waited = 0;
    while (reads_done < target && !timed_out && waited < read_timeout)
    begin
      @(negedge clk);
      waited++;
    end
    if (reads_done < target)
      flag_timeout("read result missing");
  endtask

  task automatic wait_drain();
    int waited;
    int pending;
    waited  = 0;
    pending = 1;
    while (pending != 0 && !timed_out && waited < read_timeout)
    begin
      @(negedge clk);
      waited++;
      pending = 0;
      for (int c = 0; c < num_chan; c++)
        pending += exp_q[c].size();
    end
    if (pending != 0)
      flag_timeout("outstanding reads never returned");
  endtask

  // Every engine ready and no result left in the output register
  task automatic wait_idle();
    int waited;
    int idle_run;
    waited   = 0;
    idle_run = 0;
    while (idle_run < num_chan && !timed_out && waited < read_timeout)
    begin
      @(negedge clk);
      cmd_chan = chan_id_t'(waited);
      #1;
      if (cmd_ready && !rd_valid)
        idle_run++;
      else
        idle_run = 0;
      waited++;
    end
    if (idle_run < num_chan)
      flag_timeout("hub never went idle");
  endtask

  task automatic start_test(input string name);
    cur_test       = name;
    test_err_start = err_count;
    test_count++;
  endtask

  task automatic end_test();
    int errs;
    if (|frame_err)
    begin
      $display("%s: slave model flagged a frame error, channels %b", cur_test, frame_err);
      err_count++;
    end
    errs = err_count - test_err_start;
    if (errs != 0)
      failed_tests++;
    $display("%s finished with %0d error(s)", cur_test, errs);
  endtask

  // Read port: stall choice, stability while stalled, queue check on accept
  always @(negedge clk)
  begin
    if (held)
    begin
      if (!rd_valid)
      begin
        $display("%s: rd_valid dropped before the result was accepted", cur_test);
        err_count++;
      end
      else
      begin
        compare_data({cur_test, " stall"}, held_data, rd_data);
        compare_chan({cur_test, " stall"}, held_chan, rd_chan);
      end
    end
    stall_rng = xorshift32(stall_rng);
    rd_ready  = rst_n && !(stall_en && stall_rng[1:0] == 2'b00);
    held      = rd_valid && !rd_ready;
    held_data = rd_data;
    held_chan = rd_chan;
    if (rd_valid && rd_ready)
    begin
      if (exp_q[rd_chan].size() == 0)
      begin
        $display("%s: result on channel %0d with no read outstanding", cur_test, rd_chan);
        err_count++;
      end
      else
        compare_data(cur_test, exp_q[rd_chan].pop_front(), rd_data);
      last_chan             = rd_chan;
      last_data             = rd_data;
      last_by_chan[rd_chan] = rd_data;
      reads_done++;
    end
  end

  initial
  begin
    logic [31:0] r;
    chan_id_t    ch;
    reg_addr_t   addr;
    reg_data_t   wdata;
    reg_data_t   bytes [num_chan];
    int          done_start;

    rst_n        = 1'b0;
    cmd_valid    = 1'b0;
    cmd_chan     = '0;
    cmd_word     = '0;
    cmd_rng      = 32'd53399;
    stall_rng    = 32'd53399 ^ 32'h5a5a_5a5a; // Separate stream for rd_ready
    stall_en     = 1'b0;
    held         = 1'b0;
    timed_out    = 1'b0;
    reads_done   = 0;
    err_count    = 0;
    test_count   = 0;
    failed_tests = 0;
    for (int c = 0; c < num_chan; c++)
      for (int a = 0; a < 8; a++)
        model_regs[c][a] = '0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    start_test("reset_state");
    if (cs_n !== '1 || sclk !== '0 || mosi !== '0 || rd_valid !== 1'b0)
    begin
      $display("%s: pins or rd_valid wrong after reset", cur_test);
      err_count++;
    end
    for (int c = 0; c < num_chan; c++)
    begin
      @(negedge clk);
      cmd_chan = chan_id_t'(c);
      #1;
      if (cmd_ready !== 1'b1)
      begin
        $display("%s: channel %0d not ready after reset", cur_test, c);
        err_count++;
      end
    end
    end_test();

    start_test("write_read");
    cmd_rng    = xorshift32(cmd_rng);
    r          = cmd_rng;
    ch         = r[1:0];
    addr       = r[4:2];
    wdata      = r[12:5];
    done_start = reads_done;
    send_cmd(ch, {1'b1, addr, wdata});
    send_cmd(ch, {1'b0, addr, 8'h00});
    wait_reads(done_start + 1);
    compare_chan(cur_test, ch, last_chan);
    compare_data(cur_test, wdata, last_data);
    end_test();

    start_test("all_channels");
    cmd_rng    = xorshift32(cmd_rng);
    r          = cmd_rng;
    addr       = r[2:0];
    done_start = reads_done;
    for (int c = 0; c < num_chan; c++)
    begin
      bytes[c] = r[15:8] ^ reg_data_t'(8'h11 << c); // Distinct per channel
      send_cmd(chan_id_t'(c), {1'b1, addr, bytes[c]});
    end
    for (int c = 0; c < num_chan; c++)
      send_cmd(chan_id_t'(c), {1'b0, addr, 8'h00});
    wait_reads(done_start + num_chan);
    for (int c = 0; c < num_chan; c++)
      compare_data(cur_test, bytes[c], last_by_chan[c]);
    end_test();

    start_test("random_stall");
    stall_en = 1'b1;
    for (int n = 0; n < num_cmds; n++)
    begin
      cmd_rng = xorshift32(cmd_rng);
      r       = cmd_rng;
      send_cmd(r[1:0], {r[2], r[5:3], r[13:6]});
    end
    wait_drain();
    stall_en = 1'b0;
    wait_idle(); // A duplicate result shows up here with no read outstanding
    end_test();

    $display("tests: %0d, failing: %0d, errors: %0d", test_count, failed_tests, err_count);
    if (err_count == 0)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  end

endmodule

`default_nettype wire
